//--- rtl/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // instruction offered by the pipeline
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN
    } csr_op_e;

    // content of the single stage register
    typedef enum logic [2:0] {
        MODE_NONE,
        MODE_READ,
        MODE_WRITE,
        MODE_ERTN,
        MODE_TRAP
    } stage_mode_e;

    localparam int INT_LINES = 9;   // hw0..hw7, ipi on top
    localparam int LIE_W     = 13;
    localparam int CRMD_W    = 9;   // plv[1:0] ie[2] da[3] pg[4]

    localparam logic [CRMD_W-1:0] CRMD_RESET = 9'h008;

    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    localparam ecode_t ECODE_INT = 6'h0;
    localparam ecode_t ECODE_ADE = 6'h8;
    localparam ecode_t ECODE_ALE = 6'h9;
    localparam ecode_t ECODE_SYS = 6'hb;
    localparam ecode_t ECODE_BRK = 6'hc;
    localparam ecode_t ECODE_INE = 6'hd;

endpackage

//--- rtl/csr_decode.sv
module csr_decode (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          inst_valid,
    input  csr_pkg::csr_op_e              inst_op,
    input  csr_pkg::word_t                inst_pc,
    input  csr_pkg::csr_num_t             csr_num,
    input  csr_pkg::word_t                wdata,
    input  csr_pkg::word_t                wmask,
    input  logic                          excp_valid,
    input  csr_pkg::ecode_t               excp_ecode,
    input  csr_pkg::esubcode_t            excp_esubcode,
    input  csr_pkg::word_t                bad_vaddr,
    input  logic [csr_pkg::INT_LINES-1:0] int_lines,
    input  logic                          int_pending,
    input  csr_pkg::word_t                old_value,
    output csr_pkg::stage_mode_e          st_mode,
    output logic                          st_int,
    output csr_pkg::ecode_t               st_ecode,
    output csr_pkg::esubcode_t            st_esubcode,
    output csr_pkg::word_t                st_pc,
    output csr_pkg::word_t                st_vaddr,
    output csr_pkg::csr_num_t             st_num,
    output csr_pkg::word_t                st_wdata,
    output csr_pkg::word_t                st_rdata
);
    import csr_pkg::*;

    logic        take_int;
    stage_mode_e nxt_mode;
    ecode_t      nxt_ecode;
    esubcode_t   nxt_esubcode;
    word_t       nxt_vaddr;
    word_t       nxt_wdata;
    word_t       merge_mask;

    // interrupt rides on a valid offer, never twice in a row
    assign take_int   = int_pending && inst_valid && !st_int;
    assign merge_mask = (inst_op == OP_CSRXCHG) ? wmask : '1;

    always_comb
    begin
        nxt_mode     = MODE_NONE;
        nxt_ecode    = excp_ecode;
        nxt_esubcode = excp_esubcode;
        nxt_vaddr    = inst_pc;   // fetch side faults
        nxt_wdata    = (old_value & ~merge_mask) | (wdata & merge_mask);
        if (take_int)
        begin
            nxt_mode     = MODE_TRAP;
            nxt_ecode    = ECODE_INT;
            nxt_esubcode = '0;
            nxt_wdata    = word_t'(int_lines);   // lines seen at the trap
        end
        else if (excp_valid)
        begin
            nxt_mode = MODE_TRAP;
            if (excp_ecode == ECODE_ADE || excp_ecode == ECODE_ALE)
                nxt_vaddr = bad_vaddr;
        end
        else if (inst_valid)
        begin
            case (inst_op)
                OP_CSRRD:   nxt_mode = MODE_READ;
                OP_CSRWR:   nxt_mode = MODE_WRITE;
                OP_CSRXCHG: nxt_mode = MODE_WRITE;
                OP_ERTN:    nxt_mode = MODE_ERTN;
                default:    nxt_mode = MODE_NONE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            st_mode <= MODE_NONE;
            st_int  <= 1'b0;
        end
        else if (!stall)
        begin
            if (flush && !take_int)   // interrupt wins over flush
            begin
                st_mode <= MODE_NONE;
                st_int  <= 1'b0;
            end
            else
            begin
                st_mode <= nxt_mode;
                st_int  <= take_int;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            st_ecode    <= nxt_ecode;
            st_esubcode <= nxt_esubcode;
            st_pc       <= inst_pc;
            st_vaddr    <= nxt_vaddr;
            st_num      <= csr_num;
            st_wdata    <= nxt_wdata;
            st_rdata    <= old_value;
        end
    end

endmodule

//--- rtl/csr_regfile.sv
module csr_regfile (
    input  logic                          clk,
    input  logic                          rstn,
    input  csr_pkg::csr_num_t             rd_num,
    input  logic [csr_pkg::INT_LINES-1:0] int_lines,
    input  logic                          ti_pending,
    input  csr_pkg::word_t                tval,
    input  csr_pkg::word_t                tcfg,
    input  csr_pkg::stage_mode_e          st_mode,
    input  logic                          st_int,
    input  csr_pkg::ecode_t               st_ecode,
    input  csr_pkg::esubcode_t            st_esubcode,
    input  csr_pkg::word_t                st_pc,
    input  csr_pkg::word_t                st_vaddr,
    input  csr_pkg::csr_num_t             st_num,
    input  csr_pkg::word_t                st_wdata,
    output csr_pkg::word_t                rd_value,
    output logic                          int_pending,
    output logic [csr_pkg::CRMD_W-1:0]    crmd,
    output csr_pkg::word_t                era,
    output csr_pkg::word_t                eentry,
    output logic                          tcfg_we,
    output logic                          ticlr
);
    import csr_pkg::*;

    logic [2:0]       prmd;   // pie, pplv
    logic [LIE_W-1:0] ecfg_lie;
    logic [1:0]       estat_is;   // software bits
    ecode_t           estat_ecode;
    esubcode_t        estat_esubcode;
    word_t            badv;
    logic [31:6]      eentry_va;
    word_t            save0, save1, save2, save3;
    word_t            tid;
    logic [LIE_W-1:0] int_vec;
    logic             wr_commit;

    // ipi, timer, reserved, hw lines, sw bits
    assign int_vec     = {int_lines[INT_LINES-1], ti_pending, 1'b0,
                          int_lines[INT_LINES-2:0], estat_is};
    assign int_pending = (|(int_vec & ecfg_lie)) && crmd[2];
    assign wr_commit   = (st_mode == MODE_WRITE);
    assign tcfg_we     = wr_commit && (st_num == CSR_TCFG);
    assign ticlr       = wr_commit && (st_num == CSR_TICLR) && st_wdata[0];
    assign eentry      = {eentry_va, 6'b0};

    always_comb
    begin
        case (rd_num)
            CSR_CRMD:   rd_value = word_t'(crmd);
            CSR_PRMD:   rd_value = word_t'(prmd);
            CSR_ECFG:   rd_value = word_t'(ecfg_lie);
            CSR_ESTAT:  rd_value = {1'b0, estat_esubcode, estat_ecode, 3'b0, int_vec};
            CSR_ERA:    rd_value = era;
            CSR_BADV:   rd_value = badv;
            CSR_EENTRY: rd_value = eentry;
            CSR_SAVE0:  rd_value = save0;
            CSR_SAVE1:  rd_value = save1;
            CSR_SAVE2:  rd_value = save2;
            CSR_SAVE3:  rd_value = save3;
            CSR_TID:    rd_value = tid;
            CSR_TCFG:   rd_value = tcfg;
            CSR_TVAL:   rd_value = tval;
            default:    rd_value = '0;   // ticlr reads zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= CRMD_RESET;
            prmd           <= '0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end
        else
        begin
            case (st_mode)
                MODE_TRAP:
                begin
                    prmd           <= crmd[2:0];
                    crmd[2:0]      <= 3'b0;
                    estat_ecode    <= st_int ? ECODE_INT : st_ecode;
                    estat_esubcode <= st_int ? '0 : st_esubcode;
                end
                MODE_ERTN:
                    crmd[2:0] <= prmd;
                MODE_WRITE:
                begin
                    case (st_num)
                        CSR_CRMD:
                        begin
                            crmd[2:0]        <= st_wdata[2:0];
                            crmd[CRMD_W-1:5] <= st_wdata[CRMD_W-1:5];
                            if (st_wdata[4] ^ st_wdata[3])   // da and pg one-hot only
                                crmd[4:3] <= st_wdata[4:3];
                        end
                        CSR_PRMD:  prmd     <= st_wdata[2:0];
                        CSR_ECFG:  ecfg_lie <= {st_wdata[12:11], 1'b0, st_wdata[9:0]};
                        CSR_ESTAT: estat_is <= st_wdata[1:0];
                        default:   ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (st_mode == MODE_TRAP)
        begin
            era <= st_pc;
            if (!st_int && (st_ecode == ECODE_ADE || st_ecode == ECODE_ALE))
                badv <= st_vaddr;
        end
        else if (wr_commit)
        begin
            case (st_num)
                CSR_ERA:    era       <= st_wdata;
                CSR_BADV:   badv      <= st_wdata;
                CSR_EENTRY: eentry_va <= st_wdata[31:6];
                CSR_SAVE0:  save0     <= st_wdata;
                CSR_SAVE1:  save1     <= st_wdata;
                CSR_SAVE2:  save2     <= st_wdata;
                CSR_SAVE3:  save3     <= st_wdata;
                CSR_TID:    tid       <= st_wdata;
                default:    ;
            endcase
        end
    end

endmodule

//--- rtl/csr_timer.sv
module csr_timer (
    input  logic           clk,
    input  logic           rstn,
    input  logic           tcfg_we,
    input  csr_pkg::word_t wdata,
    input  logic           ticlr,
    output csr_pkg::word_t tcfg,
    output csr_pkg::word_t tval,
    output logic           ti_pending
);
    import csr_pkg::*;

    logic tcfg_load;   // new tcfg reaches tval one edge later
    logic en;
    logic periodic;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg       <= '0;
            tval       <= '0;
            tcfg_load  <= 1'b0;
            ti_pending <= 1'b0;
        end
        else
        begin
            tcfg_load <= tcfg_we;
            if (tcfg_we)
                tcfg <= wdata;

            if (ticlr)
                ti_pending <= 1'b0;
            else if (en && tval == '0 && !tcfg_load)
                ti_pending <= 1'b1;

            if (tcfg_load)
                tval <= {tcfg[31:2], 2'b00};
            else if (en)
            begin
                if (tval == '0 && periodic)
                    tval <= {tcfg[31:2], 2'b00};
                else if (tval != '1)   // one-shot parks at all ones
                    tval <= tval - 32'd1;
            end
        end
    end

endmodule

//--- rtl/csr_redirect.sv
module csr_redirect (
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_pkg::stage_mode_e st_mode,
    input  logic                 st_int,
    input  csr_pkg::word_t       st_pc,
    input  csr_pkg::word_t       era,
    input  csr_pkg::word_t       eentry,
    output logic                 pipe_flush,
    output logic                 int_flush,
    output csr_pkg::word_t       redirect_pc,
    output logic                 excp_flush,
    output logic                 ertn_flush
);
    import csr_pkg::*;

    // reads and empty slots let the pipeline run on
    assign pipe_flush = (st_mode == MODE_WRITE) || (st_mode == MODE_ERTN)
                        || (st_mode == MODE_TRAP);
    assign int_flush  = (st_mode == MODE_TRAP) && st_int;

    always_comb
    begin
        case (st_mode)
            MODE_TRAP:
                redirect_pc = eentry;
            MODE_ERTN:
                redirect_pc = era;
            default:
                redirect_pc = st_pc + 32'd4;
        endcase
    end

    // pulses line up with the commit edge
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= (st_mode == MODE_TRAP);
            ertn_flush <= (st_mode == MODE_ERTN);
        end
    end

endmodule

//--- rtl/csr_unit.sv
module csr_unit (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          inst_valid,
    input  csr_pkg::csr_op_e              inst_op,
    input  csr_pkg::word_t                inst_pc,
    input  csr_pkg::csr_num_t             csr_num,
    input  csr_pkg::word_t                wdata,
    input  csr_pkg::word_t                wmask,
    input  logic                          excp_valid,
    input  csr_pkg::ecode_t               excp_ecode,
    input  csr_pkg::esubcode_t            excp_esubcode,
    input  csr_pkg::word_t                bad_vaddr,
    input  logic [csr_pkg::INT_LINES-1:0] int_lines,
    output csr_pkg::word_t                rdata,
    output logic                          pipe_flush,
    output logic                          int_flush,
    output csr_pkg::word_t                redirect_pc,
    output logic                          excp_flush,
    output logic                          ertn_flush,
    output logic [csr_pkg::CRMD_W-1:0]    crmd
);
    import csr_pkg::*;

    stage_mode_e st_mode;
    logic        st_int;
    ecode_t      st_ecode;
    esubcode_t   st_esubcode;
    word_t       st_pc, st_vaddr, st_wdata;
    csr_num_t    st_num;
    word_t       rd_value;
    logic        int_pending;
    word_t       era, eentry;
    logic        tcfg_we, ticlr;
    word_t       tcfg, tval;
    logic        ti_pending;

    csr_decode csr_decode_i (
        .old_value (rd_value),
        .st_rdata  (rdata),
        .*
    );

    csr_regfile csr_regfile_i (
        .rd_num (csr_num),
        .*
    );

    csr_timer csr_timer_i (
        .wdata (st_wdata),   // committed write value
        .*
    );

    csr_redirect csr_redirect_i (.*);

endmodule

//--- verification/tb_csr_unit.sv
module tb_csr_unit;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_pkg::*;

    localparam int          CLK_PERIOD    = 40;
    localparam logic [31:0] SEED          = 32'd28;
    localparam int          PULSE_TIMEOUT = 8;
    localparam int          TIMER_TIMEOUT = 100;   // tval polls

    logic                 clk, rstn, stall, flush, inst_valid, excp_valid;
    csr_op_e              inst_op;
    word_t                inst_pc, wdata, wmask, bad_vaddr;
    csr_num_t             csr_num;
    ecode_t               excp_ecode;
    esubcode_t            excp_esubcode;
    logic [INT_LINES-1:0] int_lines;
    word_t                rdata, redirect_pc;
    logic                 pipe_flush, int_flush, excp_flush, ertn_flush;
    logic [CRMD_W-1:0]    crmd;

    // reference model state
    logic [CRMD_W-1:0] m_crmd;
    logic [2:0]        m_prmd;
    logic [LIE_W-1:0]  m_lie;
    logic [1:0]        m_is;
    ecode_t            m_ecode;
    esubcode_t         m_esub;
    word_t             m_era, m_badv, m_eentry, m_tcfg, m_tid;
    word_t             m_save [4];
    logic              m_ti;

    logic [31:0] lfsr;
    word_t       r_rdata, r_redir, r_pc;
    logic        r_pipe, r_int;

    csr_unit csr_unit_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic csr_num_t pick_data_csr(input logic [2:0] sel);
        case (sel)
            3'd0:    return CSR_SAVE0;
            3'd1:    return CSR_SAVE1;
            3'd2:    return CSR_SAVE2;
            3'd3:    return CSR_SAVE3;
            3'd4:    return CSR_TID;
            default: return CSR_EENTRY;
        endcase
    endfunction

    function automatic ecode_t pick_ecode(input logic [2:0] sel);
        case (sel)
            3'd1:    return ECODE_ALE;
            3'd2:    return ECODE_SYS;
            3'd3:    return ECODE_BRK;
            3'd4:    return ECODE_INE;
            default: return ECODE_ADE;
        endcase
    endfunction

    function automatic word_t model_read(input csr_num_t num);
        case (num)
            CSR_CRMD:   return word_t'(m_crmd);
            CSR_PRMD:   return word_t'(m_prmd);
            CSR_ECFG:   return word_t'(m_lie);
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, int_lines[8], m_ti, 1'b0,
                                int_lines[7:0], m_is};
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            CSR_TID:    return m_tid;
            CSR_TCFG:   return m_tcfg;
            default:    return '0;
        endcase
    endfunction

    function automatic void model_write(input csr_num_t num, input word_t v);
        case (num)
            CSR_CRMD:
            begin
                m_crmd[2:0] = v[2:0];
                m_crmd[8:5] = v[8:5];
                if (v[3] != v[4])   // da/pg only as a one-hot pair
                    m_crmd[4:3] = v[4:3];
            end
            CSR_PRMD:   m_prmd   = v[2:0];
            CSR_ECFG:   m_lie    = {v[12:11], 1'b0, v[9:0]};
            CSR_ESTAT:  m_is     = v[1:0];
            CSR_ERA:    m_era    = v;
            CSR_BADV:   m_badv   = v;
            CSR_EENTRY: m_eentry = {v[31:6], 6'b0};
            CSR_SAVE0:  m_save[0] = v;
            CSR_SAVE1:  m_save[1] = v;
            CSR_SAVE2:  m_save[2] = v;
            CSR_SAVE3:  m_save[3] = v;
            CSR_TID:    m_tid    = v;
            CSR_TCFG:   m_tcfg   = v;
            CSR_TICLR:  if (v[0]) m_ti = 1'b0;
            default:    ;
        endcase
    endfunction

    function automatic void model_trap(input ecode_t code, input esubcode_t sub,
                                       input word_t pc, input word_t vaddr);
        m_prmd      = m_crmd[2:0];
        m_crmd[2:0] = 3'b0;
        m_era       = pc;
        m_ecode     = code;
        m_esub      = sub;
        if (code == ECODE_ADE || code == ECODE_ALE)
            m_badv = vaddr;
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timed out at %0t ns waiting for %s", $time, what);
        $display("Regression failed");
        $fatal(1, "timeout");
    endtask

    task automatic idle_inputs();
        inst_valid = 1'b0;
        inst_op    = OP_NONE;
        excp_valid = 1'b0;
        flush      = 1'b0;
    endtask

    // offer at a falling edge, sample the stage, then let it commit
    task automatic do_op(input csr_op_e op, input csr_num_t num, input word_t data,
                         input word_t mask);
        inst_valid = 1'b1;
        inst_op    = op;
        csr_num    = num;
        wdata      = data;
        wmask      = mask;
        inst_pc    = rand_bits(30) << 2;
        r_pc       = inst_pc;
        @(posedge clk);
        @(negedge clk);
        r_rdata = rdata;
        r_pipe  = pipe_flush;
        r_int   = int_flush;
        r_redir = redirect_pc;
        idle_inputs();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic csr_access(input csr_op_e op, input csr_num_t num, input word_t data,
                              input word_t mask);
        word_t old, merged;
        old    = model_read(num);
        merged = (op == OP_CSRXCHG) ? ((old & ~mask) | (data & mask)) : data;
        do_op(op, num, data, mask);
        check_word(r_rdata, old, "rdata");
        check_flag(r_pipe, op != OP_CSRRD, "pipe_flush");
        check_flag(r_int, 1'b0, "int_flush");
        check_word(r_redir, r_pc + 32'd4, "redirect_pc");
        if (op != OP_CSRRD)
            model_write(num, merged);
    endtask

    task automatic wait_pulse(input logic want_ertn);
        int   n;
        logic seen;
        n    = 0;
        seen = want_ertn ? ertn_flush : excp_flush;
        while (!seen && n < PULSE_TIMEOUT)
        begin
            @(negedge clk);
            n++;
            seen = want_ertn ? ertn_flush : excp_flush;
        end
        if (!seen)
            fail_timeout(want_ertn ? "ertn_flush" : "excp_flush");
    endtask

    initial
    begin
        csr_num_t  num;
        word_t     mask, vaddr, prev, data;
        ecode_t    code;
        esubcode_t sub;
        int        k, n;
        logic      seen;

        lfsr        = SEED;
        rstn        = 1'b0;
        stall       = 1'b0;
        inst_pc     = '0;
        csr_num     = '0;
        wdata       = '0;
        wmask       = '0;
        excp_ecode  = '0;
        excp_esubcode = '0;
        bad_vaddr   = '0;
        int_lines   = '0;
        idle_inputs();
        m_crmd  = 9'h008;   // da set
        m_prmd  = '0;
        m_lie   = '0;
        m_is    = '0;
        m_ecode = '0;
        m_esub  = '0;
        m_tcfg  = '0;
        m_ti    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        check_flag(pipe_flush, 1'b0, "pipe_flush after reset");
        check_flag(int_flush, 1'b0, "int_flush after reset");
        check_flag(excp_flush, 1'b0, "excp_flush after reset");
        check_flag(ertn_flush, 1'b0, "ertn_flush after reset");
        check_word(word_t'(crmd), word_t'(m_crmd), "crmd after reset");

        // data csrs come out of reset unknown
        for (int i = 0; i < 6; i++)
        begin
            num  = pick_data_csr(3'(i));
            data = rand_bits(32);
            do_op(OP_CSRWR, num, data, '1);
            model_write(num, data);
        end

        for (int i = 0; i < 10; i++)
        begin
            num = pick_data_csr(3'(rand_bits(3)));
            csr_access(OP_CSRWR, num, rand_bits(32), '1);
            csr_access(OP_CSRRD, num, '0, '0);
            mask = rand_bits(32);
            csr_access(OP_CSRXCHG, num, rand_bits(32), mask);
            csr_access(OP_CSRRD, num, '0, '0);
        end

        // flushed write must not land
        num   = pick_data_csr(3'(rand_bits(3)));
        flush = 1'b1;
        do_op(OP_CSRWR, num, rand_bits(32), '1);
        check_flag(r_pipe, 1'b0, "pipe_flush on flushed write");
        csr_access(OP_CSRRD, num, '0, '0);

        csr_access(OP_CSRWR, CSR_EENTRY, rand_bits(32), '1);
        for (int i = 0; i < 6; i++)
        begin
            csr_access(OP_CSRWR, CSR_CRMD, rand_bits(32) | 32'h4, '1);
            code          = pick_ecode(3'(rand_bits(3)));
            sub           = esubcode_t'(rand_bits(9));
            vaddr         = rand_bits(32);
            excp_valid    = 1'b1;
            excp_ecode    = code;
            excp_esubcode = sub;
            bad_vaddr     = vaddr;
            do_op(OP_CSRRD, CSR_SAVE0, '0, '0);
            model_trap(code, sub, r_pc, vaddr);
            check_word(r_redir, m_eentry, "trap redirect_pc");
            check_flag(r_pipe, 1'b1, "pipe_flush on trap");
            check_flag(r_int, 1'b0, "int_flush on exception");
            wait_pulse(1'b0);
            csr_access(OP_CSRRD, CSR_ERA, '0, '0);
            csr_access(OP_CSRRD, CSR_ESTAT, '0, '0);
            csr_access(OP_CSRRD, CSR_PRMD, '0, '0);
            csr_access(OP_CSRRD, CSR_CRMD, '0, '0);
            if (code == ECODE_ADE || code == ECODE_ALE)
                csr_access(OP_CSRRD, CSR_BADV, '0, '0);
            do_op(OP_ERTN, CSR_CRMD, '0, '0);
            check_word(r_redir, m_era, "ertn redirect_pc");
            check_flag(r_pipe, 1'b1, "pipe_flush on ertn");
            m_crmd[2:0] = m_prmd;
            wait_pulse(1'b1);
            csr_access(OP_CSRRD, CSR_CRMD, '0, '0);
            check_word(word_t'(crmd), word_t'(m_crmd), "crmd port");
        end

        // hardware line k, enabled through lie bit k+2
        k = int'(rand_bits(3));
        csr_access(OP_CSRWR, CSR_CRMD, rand_bits(32) | 32'h4, '1);
        csr_access(OP_CSRWR, CSR_ECFG, word_t'(1) << (k + 2), '1);
        int_lines[k] = 1'b1;
        do_op(OP_CSRRD, CSR_SAVE1, '0, '0);
        model_trap(ECODE_INT, '0, r_pc, '0);
        check_flag(r_int, 1'b1, "int_flush on interrupt");
        check_flag(r_pipe, 1'b1, "pipe_flush on interrupt");
        check_word(r_redir, m_eentry, "interrupt redirect_pc");
        wait_pulse(1'b0);
        int_lines = '0;
        csr_access(OP_CSRRD, CSR_ESTAT, '0, '0);
        csr_access(OP_CSRRD, CSR_ERA, '0, '0);
        csr_access(OP_CSRRD, CSR_CRMD, '0, '0);
        int_lines[k] = 1'b1;   // ie now clear
        csr_access(OP_CSRRD, CSR_SAVE1, '0, '0);
        int_lines = '0;
        csr_access(OP_CSRWR, CSR_ECFG, '0, '1);

        csr_access(OP_CSRWR, CSR_TCFG, ((rand_bits(5) + 32'd8) << 2) | 32'h1, '1);
        csr_access(OP_CSRRD, CSR_TCFG, '0, '0);
        prev = '1;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMER_TIMEOUT)
        begin
            do_op(OP_CSRRD, CSR_TVAL, '0, '0);
            check_flag(r_rdata <= prev || r_rdata == '1, 1'b1, "tval never increases");
            prev = r_rdata;
            do_op(OP_CSRRD, CSR_ESTAT, '0, '0);
            seen = r_rdata[11];
            n++;
        end
        if (!seen)
            fail_timeout("timer interrupt in ESTAT");
        m_ti = 1'b1;
        csr_access(OP_CSRRD, CSR_ESTAT, '0, '0);
        csr_access(OP_CSRWR, CSR_TICLR, 32'h1, '1);
        csr_access(OP_CSRRD, CSR_ESTAT, '0, '0);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_regfile.sv
rtl/csr_timer.sv
rtl/csr_redirect.sv
rtl/csr_unit.sv
verification/tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/csr_decode.sv
      - rtl/csr_regfile.sv
      - rtl/csr_timer.sv
      - rtl/csr_redirect.sv
      - rtl/csr_unit.sv
  - target: simulation
    files:
      - verification/tb_csr_unit.sv
